/* common/debugPkg.sv */
`default_nettype none

package debugPkg;

    // ========================================================================
    // Data types
    // ========================================================================

    // Command, response and FIFO payload
    typedef logic [7:0] byteT;

    // One bit per LED
    typedef logic [3:0] ledT;

    // ========================================================================
    // FIFO geometry
    // ========================================================================

    localparam int FifoDepth = 8;
    // Pointers carry one more bit than this to tell full from empty
    localparam int FifoAddrW = 3;

    // ========================================================================
    // Command encoding
    // ========================================================================

    // 0x80..0x87 set LED bits[2:1] to bit[0]
    localparam byteT CmdLedMask = 8'hF8;
    localparam byteT CmdLedBase = 8'h80;

    // Reply bytes that follow the length byte
    localparam byteT RespLen = 8'd3;

    // ========================================================================
    // State machines
    // ========================================================================

    typedef enum logic [1:0] {Idle, SendLen, SendBody} bridgeStateT;

    typedef enum logic [1:0] {WaitCmd, Reply0, Reply1, Reply2} handlerStateT;

endpackage

`default_nettype wire

/* hdl/asyncFifo.sv */
`default_nettype none

module asyncFifo (
    input  wire                 wrClk,
    input  wire                 wrRst,
    input  wire                 wrEn,
    input  wire debugPkg::byteT wrData,
    output logic                full,
    input  wire                 rdClk,
    input  wire                 rdRst,
    input  wire                 rdEn,
    output debugPkg::byteT      rdData,
    output logic                empty
);

    debugPkg::byteT mem [debugPkg::FifoDepth];

    logic [debugPkg::FifoAddrW:0] wrBin;
    logic [debugPkg::FifoAddrW:0] wrBinNext;
    logic [debugPkg::FifoAddrW:0] wrGray;
    logic [debugPkg::FifoAddrW:0] rdBin;
    logic [debugPkg::FifoAddrW:0] rdBinNext;
    logic [debugPkg::FifoAddrW:0] rdGray;

    // Gray pointers seen from the other side
    logic [debugPkg::FifoAddrW:0] rdGrayMeta;
    logic [debugPkg::FifoAddrW:0] rdGraySync;
    logic [debugPkg::FifoAddrW:0] wrGrayMeta;
    logic [debugPkg::FifoAddrW:0] wrGraySync;

    logic wrAccept;
    logic rdAccept;

    // ========================================================================
    // Write side
    // ========================================================================

    assign wrAccept  = wrEn & ~full;
    assign wrBinNext = wrBin + 1'b1;

    always_ff @(posedge wrClk) begin
        if (wrRst) begin
            wrBin <= '0;
            wrGray <= '0;
        end else if (wrAccept) begin
            wrBin <= wrBinNext;
            wrGray <= wrBinNext ^ (wrBinNext >> 1);
        end
    end

    always_ff @(posedge wrClk) begin
        if (wrAccept) begin
            mem[wrBin[debugPkg::FifoAddrW-1:0]] <= wrData;
        end
    end

    always_ff @(posedge wrClk) begin
        if (wrRst) begin
            rdGrayMeta <= '0;
            rdGraySync <= '0;
        end else begin
            rdGrayMeta <= rdGray;
            rdGraySync <= rdGrayMeta;
        end
    end

    // Full when the writer is one lap ahead: top two Gray bits inverted
    assign full = (wrGray == {~rdGraySync[debugPkg::FifoAddrW -: 2],
                              rdGraySync[debugPkg::FifoAddrW-2:0]});

    // ========================================================================
    // Read side
    // ========================================================================

    assign rdAccept  = rdEn & ~empty;
    assign rdBinNext = rdBin + 1'b1;

    always_ff @(posedge rdClk) begin
        if (rdRst) begin
            rdBin <= '0;
            rdGray <= '0;
        end else if (rdAccept) begin
            rdBin <= rdBinNext;
            rdGray <= rdBinNext ^ (rdBinNext >> 1);
        end
    end

    always_ff @(posedge rdClk) begin
        if (rdRst) begin
            wrGrayMeta <= '0;
            wrGraySync <= '0;
        end else begin
            wrGrayMeta <= wrGray;
            wrGraySync <= wrGrayMeta;
        end
    end

    assign empty = (rdGray == wrGraySync);

    // Head entry shows through while not empty
    assign rdData = mem[rdBin[debugPkg::FifoAddrW-1:0]];

endmodule

`default_nettype wire

/* debugLink/debugShifter.sv */
`default_nettype none

module debugShifter (
    input  wire                 debugClk,
    input  wire                 rst,
    input  wire                 debugCs,
    input  wire                 debugDi,
    output logic                debugDo,
    output logic                inWrEn,
    output debugPkg::byteT      inWrData,
    input  wire                 inFull,
    input  wire debugPkg::byteT outData,
    input  wire                 outEmpty,
    output logic                outRdEn
);

    logic rstMeta;
    logic rstSync;

    debugPkg::byteT inShift;

    // Start bit on top, then the data byte MSB first
    logic [8:0] outShift;
    // Edges left in the current outgoing frame
    logic [3:0] outCnt;
    logic       outLoad;

    // Bring the system reset onto the debug clock
    always_ff @(posedge debugClk) begin
        rstMeta <= rst;
        rstSync <= rstMeta;
    end

    // ========================================================================
    // Incoming bytes
    // ========================================================================

    // A byte is complete once a 1 has reached bit 7; drop it if the FIFO is full
    assign inWrEn   = debugCs & inShift[7] & ~inFull;
    assign inWrData = inShift;

    // ========================================================================
    // Outgoing bytes
    // ========================================================================

    // Next byte can load on the last edge of the current frame
    assign outLoad = debugCs & (outCnt <= 4'd1) & ~outEmpty;
    assign outRdEn = outLoad;
    assign debugDo = outShift[8];

    always_ff @(posedge debugClk) begin
        if (rstSync) begin
            inShift <= '0;
            outShift <= '0;
            outCnt <= '0;
        end else if (debugCs) begin
            if (inShift[7]) begin
                inShift <= {7'b0, debugDi};
            end else begin
                inShift <= {inShift[6:0], debugDi};
            end

            if (outLoad) begin
                outShift <= {1'b1, outData};
                outCnt <= 4'd9;
            end else begin
                // Zero fill keeps the line low once the frame is out
                outShift <= {outShift[7:0], 1'b0};
                if (outCnt != 4'd0) begin
                    outCnt <= outCnt - 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* debugLink/debugBridge.sv */
`default_nettype none

module debugBridge (
    input  wire                 clk,
    input  wire                 rst,
    output logic                cmdValid,
    output debugPkg::byteT      cmdData,
    input  wire                 cmdReady,
    input  wire                 respValid,
    input  wire debugPkg::byteT respData,
    input  wire                 respLast,
    output logic                respReady,
    input  wire                 debugClk,
    input  wire                 debugCs,
    input  wire                 debugDi,
    output logic                debugDo
);

    // Debug-side reset for the FIFO ports
    logic debugRstMeta;
    logic debugRst;

    logic           inWrEn;
    debugPkg::byteT inWrData;
    logic           inFull;
    logic           inEmpty;

    logic           outWrEn;
    debugPkg::byteT outWrData;
    logic           outFull;
    logic           outRdEn;
    debugPkg::byteT outData;
    logic           outEmpty;

    debugPkg::bridgeStateT state;
    logic                  lenWrite;

    always_ff @(posedge debugClk) begin
        debugRstMeta <= rst;
        debugRst <= debugRstMeta;
    end

    // ========================================================================
    // Command stream
    // ========================================================================

    asyncFifo inFifo (
        .wrClk  (debugClk),
        .wrRst  (debugRst),
        .wrEn   (inWrEn),
        .wrData (inWrData),
        .full   (inFull),
        .rdClk  (clk),
        .rdRst  (rst),
        .rdEn   (cmdReady),
        .rdData (cmdData),
        .empty  (inEmpty)
    );

    // FIFO ignores rdEn while empty, so cmdReady alone pops on a transfer
    assign cmdValid = ~inEmpty;

    // ========================================================================
    // Response framing
    // ========================================================================

    // Length goes in first while the handler holds its first byte
    assign lenWrite  = (state != debugPkg::SendBody) & respValid & ~outFull;
    assign respReady = (state == debugPkg::SendBody) & ~outFull;
    assign outWrEn   = lenWrite | (respValid & respReady);
    assign outWrData = lenWrite ? debugPkg::RespLen : respData;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= debugPkg::Idle;
        end else begin
            case (state)
                debugPkg::Idle, debugPkg::SendLen: begin
                    // SendLen waits out a full FIFO before the length byte
                    if (lenWrite) begin
                        state <= debugPkg::SendBody;
                    end else begin
                        state <= respValid ? debugPkg::SendLen : debugPkg::Idle;
                    end
                end
                debugPkg::SendBody: begin
                    if (respValid && respReady && respLast) begin
                        state <= debugPkg::Idle;
                    end
                end
                default: state <= debugPkg::Idle;
            endcase
        end
    end

    asyncFifo outFifo (
        .wrClk  (clk),
        .wrRst  (rst),
        .wrEn   (outWrEn),
        .wrData (outWrData),
        .full   (outFull),
        .rdClk  (debugClk),
        .rdRst  (debugRst),
        .rdEn   (outRdEn),
        .rdData (outData),
        .empty  (outEmpty)
    );

    debugShifter shifter (
        .debugClk (debugClk),
        .rst      (rst),
        .debugCs  (debugCs),
        .debugDi  (debugDi),
        .debugDo  (debugDo),
        .inWrEn   (inWrEn),
        .inWrData (inWrData),
        .inFull   (inFull),
        .outData  (outData),
        .outEmpty (outEmpty),
        .outRdEn  (outRdEn)
    );

endmodule

`default_nettype wire

/* hdl/ledCommand.sv */
`default_nettype none

module ledCommand (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 cmdValid,
    input  wire debugPkg::byteT cmdData,
    output logic                cmdReady,
    output logic                respValid,
    output debugPkg::byteT      respData,
    output logic                respLast,
    input  wire                 respReady,
    output debugPkg::ledT       led
);

    debugPkg::handlerStateT state;
    debugPkg::byteT         cmdReg;
    // Commands handled so far, wraps at 256
    debugPkg::byteT         cmdCount;

    assign cmdReady  = (state == debugPkg::WaitCmd);
    assign respValid = (state != debugPkg::WaitCmd);
    assign respLast  = (state == debugPkg::Reply2);

    always_comb begin
        case (state)
            debugPkg::Reply1: respData = {4'b0, led};
            debugPkg::Reply2: respData = cmdCount;
            default:          respData = cmdReg;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cmdValid && cmdReady) begin
            cmdReg <= cmdData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= debugPkg::WaitCmd;
            led <= '0;
            cmdCount <= '0;
        end else begin
            case (state)
                debugPkg::WaitCmd: begin
                    if (cmdValid) begin
                        cmdCount <= cmdCount + 8'd1;
                        if ((cmdData & debugPkg::CmdLedMask) == debugPkg::CmdLedBase) begin
                            led[cmdData[2:1]] <= cmdData[0];
                        end
                        state <= debugPkg::Reply0;
                    end
                end
                debugPkg::Reply0: if (respReady) state <= debugPkg::Reply1;
                debugPkg::Reply1: if (respReady) state <= debugPkg::Reply2;
                debugPkg::Reply2: if (respReady) state <= debugPkg::WaitCmd;
                default:          state <= debugPkg::WaitCmd;
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/debugTop.sv */
`default_nettype none

module debugTop (
    input  wire                clk,
    input  wire                rst,
    input  wire                debugClk,
    input  wire                debugCs,
    input  wire                debugDi,
    output logic               debugDo,
    output debugPkg::ledT      led
);

    logic           cmdValid;
    debugPkg::byteT cmdData;
    logic           cmdReady;

    logic           respValid;
    debugPkg::byteT respData;
    logic           respLast;
    logic           respReady;

    debugBridge bridge (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmdData   (cmdData),
        .cmdReady  (cmdReady),
        .respValid (respValid),
        .respData  (respData),
        .respLast  (respLast),
        .respReady (respReady),
        .debugClk  (debugClk),
        .debugCs   (debugCs),
        .debugDi   (debugDi),
        .debugDo   (debugDo)
    );

    ledCommand handler (
        .clk       (clk),
        .rst       (rst),
        .cmdValid  (cmdValid),
        .cmdData   (cmdData),
        .cmdReady  (cmdReady),
        .respValid (respValid),
        .respData  (respData),
        .respLast  (respLast),
        .respReady (respReady),
        .led       (led)
    );

endmodule

`default_nettype wire

/* sim/debugTopTb.sv */
`default_nettype none

module debugTopTb;

    localparam int NumCmds      = 300;
    localparam int QuietCycles  = 50;
    localparam int StartTimeout = 200;
    localparam int MaxGap       = 12;

    logic          clk;
    logic          rst;
    logic          debugClk;
    logic          debugCs;
    logic          debugDi;
    logic          debugDo;
    debugPkg::ledT led;

    // Reference model state
    debugPkg::ledT  modelLed;
    debugPkg::byteT modelCount;

    debugTop debugTop_i (
        .clk      (clk),
        .rst      (rst),
        .debugClk (debugClk),
        .debugCs  (debugCs),
        .debugDi  (debugDi),
        .debugDo  (debugDo),
        .led      (led)
    );

    always #2 clk = ~clk;
    always #5 debugClk = ~debugClk;

    // ========================================================================
    // Checks
    // ========================================================================

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic checkByte(input debugPkg::byteT actual, input debugPkg::byteT expected,
                             input string what);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH at %0t: %s is %02h, expected %02h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkLed(input debugPkg::ledT actual, input debugPkg::ledT expected,
                            input string what);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH at %0t: %s is %01h, expected %01h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkLine(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            failRun($sformatf("MISMATCH at %0t: %s is %b, expected %b",
                              $time, what, actual, expected));
        end
    endtask

    // ========================================================================
    // Host side of the serial link
    // ========================================================================

    // One bit per debug clock; the reply line must stay quiet meanwhile
    task automatic driveBit(input logic b);
        @(posedge debugClk);
        debugDi <= b;
        @(negedge debugClk);
        checkLine(debugDo, 1'b0, "debugDo while the host sends");
    endtask

    task automatic sendCommand(input debugPkg::byteT cmd, input int gap);
        for (int i = 0; i < gap; i++) begin
            driveBit(1'b0);
        end
        for (int i = 7; i >= 0; i--) begin
            driveBit(cmd[i]);
        end
        // Let the last data bit be sampled before going idle
        driveBit(1'b0);
    endtask

    // Samples at the falling edge, half a period away from any change
    task automatic waitStartBit(input string what);
        int cycles;
        cycles = 0;
        @(negedge debugClk);
        while (debugDo !== 1'b1) begin
            cycles++;
            if (cycles >= StartTimeout) begin
                failRun($sformatf("Timeout: no start bit for the %s within %0d debug clocks",
                                  what, StartTimeout));
            end
            @(negedge debugClk);
        end
    endtask

    task automatic collectByte(output debugPkg::byteT data);
        data = '0;
        for (int i = 0; i < 8; i++) begin
            @(negedge debugClk);
            data = {data[6:0], debugDo};
        end
    endtask

    // LED commands half the time, the rest from 0x88..0xFF
    function automatic debugPkg::byteT randomCommand();
        debugPkg::byteT cmd;
        if ($urandom_range(1) == 0) begin
            cmd = 8'h80 | 8'($urandom_range(7));
        end else begin
            cmd = 8'h88 + 8'($urandom_range(8'h77));
        end
        return cmd;
    endfunction

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial begin
        debugPkg::byteT cmd;
        debugPkg::byteT rxByte;
        int             gap;

        clk = 1'b0;
        debugClk = 1'b0;
        rst = 1'b1;
        debugCs = 1'b1;
        debugDi = 1'b0;
        modelLed = '0;
        modelCount = '0;
        void'($urandom(32'ha71a_7361));

        repeat (4) @(posedge clk);
        rst <= 1'b0;

        // The debug side sees the reset through two flops
        repeat (3) @(posedge debugClk);

        // Idle after reset
        for (int i = 0; i < QuietCycles; i++) begin
            @(negedge debugClk);
            checkLed(led, '0, "led after reset");
            checkLine(debugDo, 1'b0, "debugDo after reset");
        end

        for (int n = 0; n < NumCmds; n++) begin
            cmd = randomCommand();
            gap = $urandom_range(MaxGap);
            sendCommand(cmd, gap);

            if (cmd >= 8'h80 && cmd <= 8'h87) begin
                modelLed[cmd[2:1]] = cmd[0];
            end
            modelCount = modelCount + 8'd1;

            waitStartBit("length byte");
            checkLed(led, modelLed, "led before the reply");
            collectByte(rxByte);
            checkByte(rxByte, 8'd3, "length byte");

            waitStartBit("echo byte");
            collectByte(rxByte);
            checkByte(rxByte, cmd, "echo byte");

            waitStartBit("LED byte");
            collectByte(rxByte);
            checkByte(rxByte, {4'b0, modelLed}, "LED byte");

            waitStartBit("count byte");
            collectByte(rxByte);
            checkByte(rxByte, modelCount, "count byte");
        end

        // Nothing may follow the last reply
        for (int i = 0; i < QuietCycles; i++) begin
            @(negedge debugClk);
            checkLine(debugDo, 1'b0, "debugDo after the last reply");
            checkLed(led, modelLed, "led after the last reply");
        end

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

/* debugTop.f */
common/debugPkg.sv
hdl/asyncFifo.sv
debugLink/debugShifter.sv
debugLink/debugBridge.sv
hdl/ledCommand.sv
hdl/debugTop.sv
sim/debugTopTb.sv

/* Bender.yml */
package:
  name: debugTop

sources:
  - common/debugPkg.sv
  - hdl/asyncFifo.sv
  - debugLink/debugShifter.sv
  - debugLink/debugBridge.sv
  - hdl/ledCommand.sv
  - hdl/debugTop.sv
  - target: simulation
    files:
      - sim/debugTopTb.sv
